/* src/isaPkg.sv */
// ISA widths, opcode and ext codes, link register and the instruction word union
package isaPkg;

    localparam int dataW    = 16;                 // Datapath width
    localparam int regAddrW = 3;                  // Eight registers
    localparam int numRegs  = 1 << regAddrW;
    localparam int opW      = 5;                  // Opcode field
    localparam int extW     = 2;                  // R-format function bits
    localparam int imm5W    = 5;                  // I-format 1 immediate
    localparam int imm8W    = 8;                  // I-format 2 immediate
    localparam int dispW    = 11;                 // J-format displacement

    localparam logic [opW-1:0] opAlu   = 5'b11011; // R-format group
    localparam logic [opW-1:0] opAddi  = 5'b01000;
    localparam logic [opW-1:0] opSubi  = 5'b01001;
    localparam logic [opW-1:0] opXori  = 5'b01010;
    localparam logic [opW-1:0] opAndni = 5'b01011;
    localparam logic [opW-1:0] opLbi   = 5'b11000;
    localparam logic [opW-1:0] opJal   = 5'b00110;
    localparam logic [opW-1:0] opJalr  = 5'b00111;

    localparam logic [extW-1:0] extAdd  = 2'b00;
    localparam logic [extW-1:0] extSub  = 2'b01;  // Rt minus Rs
    localparam logic [extW-1:0] extXor  = 2'b10;
    localparam logic [extW-1:0] extAndn = 2'b11;

    localparam logic [regAddrW-1:0] linkReg = 3'd7; // JAL and JALR destination

    typedef struct packed {
        logic [opW-1:0]   opcode;
        logic [dispW-1:0] disp;
    } jFmtT;

    typedef struct packed {
        logic [opW-1:0]      opcode;
        logic [regAddrW-1:0] rs;
        logic [regAddrW-1:0] rd;                  // Destination sits in 7..5 here
        logic [imm5W-1:0]    imm;
    } i1FmtT;

    typedef struct packed {
        logic [opW-1:0]      opcode;
        logic [regAddrW-1:0] rs;
        logic [imm8W-1:0]    imm;
    } i2FmtT;

    typedef struct packed {
        logic [opW-1:0]      opcode;
        logic [regAddrW-1:0] rs;
        logic [regAddrW-1:0] rt;
        logic [regAddrW-1:0] rd;
        logic [extW-1:0]     ext;
    } rFmtT;

    // Same 16 bits seen through each format
    typedef union packed {
        jFmtT  jFmt;
        i1FmtT i1Fmt;
        i2FmtT i2Fmt;
        rFmtT  rFmt;
    } instrWord;

endpackage

/* src/ctrlPkg.sv */
// ALU operation codes and immediate select codes for the control signals
package ctrlPkg;

    localparam int aluOpW  = 3;
    localparam int immSelW = 2;

    localparam logic [aluOpW-1:0] aluAdd     = 3'd0;
    localparam logic [aluOpW-1:0] aluSubRev  = 3'd1; // Second operand minus first
    localparam logic [aluOpW-1:0] aluXor     = 3'd2;
    localparam logic [aluOpW-1:0] aluAndn    = 3'd3; // First and not second
    localparam logic [aluOpW-1:0] aluPassImm = 3'd4; // LBI

    localparam logic [immSelW-1:0] immI1Sext = 2'd0;
    localparam logic [immSelW-1:0] immI1Zext = 2'd1;
    localparam logic [immSelW-1:0] immI2Sext = 2'd2;

endpackage

/* src/instrDecoder.sv */
// Control unit mapping opcode and ext bits to the decode and execute controls
`timescale 1ns/1ps

module instrDecoder (
    input  logic [isaPkg::opW-1:0]      opcode,
    input  logic [isaPkg::extW-1:0]     ext,
    output logic                        regDst,   // Destination is R-format Rd
    output logic                        i1Sel,    // I-format 1, Rd in 7..5 and imm operand
    output logic                        link,     // Write pc to R7
    output logic                        writeEn,
    output logic                        jump,
    output logic                        jumpReg,  // Target based on Rs
    output logic                        illegal,
    output logic [ctrlPkg::aluOpW-1:0]  aluOp,
    output logic [ctrlPkg::immSelW-1:0] immSel
);

    always_comb begin
        regDst  = 1'b0;                           // Defaults for an illegal word
        i1Sel   = 1'b0;
        link    = 1'b0;
        writeEn = 1'b0;
        jump    = 1'b0;
        jumpReg = 1'b0;
        illegal = 1'b0;
        aluOp   = ctrlPkg::aluAdd;
        immSel  = ctrlPkg::immI1Sext;

        case (opcode)
            isaPkg::opAlu: begin
                regDst  = 1'b1;
                writeEn = 1'b1;
                case (ext)                        // All four ext codes are used
                    isaPkg::extAdd: aluOp = ctrlPkg::aluAdd;
                    isaPkg::extSub: aluOp = ctrlPkg::aluSubRev;
                    isaPkg::extXor: aluOp = ctrlPkg::aluXor;
                    isaPkg::extAndn: aluOp = ctrlPkg::aluAndn;
                    default: aluOp = ctrlPkg::aluAdd;
                endcase
            end
            isaPkg::opAddi, isaPkg::opSubi, isaPkg::opXori, isaPkg::opAndni: begin
                i1Sel   = 1'b1;
                writeEn = 1'b1;
                case (opcode)
                    isaPkg::opSubi: aluOp = ctrlPkg::aluSubRev; // Imm minus Rs
                    isaPkg::opXori: aluOp = ctrlPkg::aluXor;
                    isaPkg::opAndni: aluOp = ctrlPkg::aluAndn;
                    default: aluOp = ctrlPkg::aluAdd;
                endcase
                // Logical ops take the zero-extended immediate
                if (opcode == isaPkg::opXori || opcode == isaPkg::opAndni) begin
                    immSel = ctrlPkg::immI1Zext;
                end
            end
            isaPkg::opLbi: begin
                writeEn = 1'b1;                   // Writes Rs
                aluOp   = ctrlPkg::aluPassImm;
                immSel  = ctrlPkg::immI2Sext;
            end
            isaPkg::opJal: begin
                link    = 1'b1;
                writeEn = 1'b1;
                jump    = 1'b1;
            end
            isaPkg::opJalr: begin
                link    = 1'b1;
                writeEn = 1'b1;
                jump    = 1'b1;
                jumpReg = 1'b1;
                immSel  = ctrlPkg::immI2Sext;
            end
            default: illegal = 1'b1;              // No write for unknown codes
        endcase
    end

endmodule

/* src/regFile.sv */
// Eight by 16-bit register file with same-cycle write to read bypass
`timescale 1ns/1ps

module regFile (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [isaPkg::regAddrW-1:0] rdSel1,
    input  logic [isaPkg::regAddrW-1:0] rdSel2,
    output logic [isaPkg::dataW-1:0]    rdData1,
    output logic [isaPkg::dataW-1:0]    rdData2,
    input  logic                        wrEn,
    input  logic [isaPkg::regAddrW-1:0] wrSel,
    input  logic [isaPkg::dataW-1:0]    wrData
);

    logic [isaPkg::dataW-1:0] regs [isaPkg::numRegs];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < isaPkg::numRegs; i++) begin
                regs[i] <= '0;                    // All registers read zero after reset
            end
        end else if (wrEn) begin
            regs[wrSel] <= wrData;
        end
    end

    // Bypass so a reader in the writeback cycle sees the new value
    assign rdData1 = (wrEn && wrSel == rdSel1) ? wrData : regs[rdSel1];
    assign rdData2 = (wrEn && wrSel == rdSel2) ? wrData : regs[rdSel2];

endmodule

/* src/decode.sv */
// Decode stage with field extraction, destination select, immediate build and stage register
`timescale 1ns/1ps

module decode (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        inValid,
    output logic                        inReady,
    input  isaPkg::instrWord            inInstr,
    input  logic [isaPkg::dataW-1:0]    inPc,      // Next-instruction pc
    input  logic                        regDst,
    input  logic                        i1Sel,
    input  logic                        link,
    input  logic                        writeEn,
    input  logic                        jump,
    input  logic                        jumpReg,
    input  logic                        illegal,
    input  logic [ctrlPkg::aluOpW-1:0]  aluOp,
    input  logic [ctrlPkg::immSelW-1:0] immSel,
    output logic [isaPkg::opW-1:0]      opcode,
    output logic [isaPkg::extW-1:0]     ext,
    output logic                        dValid,
    input  logic                        dReady,
    output logic [isaPkg::dataW-1:0]    dOpA,
    output logic [isaPkg::dataW-1:0]    dOpB,
    output logic [isaPkg::dataW-1:0]    dImm,
    output logic [isaPkg::dataW-1:0]    dDisp,
    output logic [isaPkg::dataW-1:0]    dPc,
    output logic [isaPkg::regAddrW-1:0] dDest,
    output logic [ctrlPkg::aluOpW-1:0]  dAluOp,
    output logic                        dWrite,
    output logic                        dLink,
    output logic                        dJump,
    output logic                        dJumpReg,
    output logic                        dErr,
    input  logic                        wbEn,
    input  logic [isaPkg::regAddrW-1:0] wbReg,
    input  logic [isaPkg::dataW-1:0]    wbData
);

    logic [isaPkg::dataW-1:0]    rdData1;         // Rs
    logic [isaPkg::dataW-1:0]    rdData2;         // Rt
    logic [isaPkg::dataW-1:0]    immVal;
    logic [isaPkg::dataW-1:0]    dispVal;
    logic [isaPkg::regAddrW-1:0] destSel;
    logic                        inFire;

    assign opcode  = inInstr.rFmt.opcode;
    assign ext     = inInstr.rFmt.ext;
    assign inReady = !dValid || dReady;           // Free or draining this cycle
    assign inFire  = inValid && inReady;

    regFile uRegFile (
        .clk     (clk),
        .rstN    (rstN),
        .rdSel1  (inInstr.rFmt.rs),
        .rdSel2  (inInstr.rFmt.rt),
        .rdData1 (rdData1),
        .rdData2 (rdData2),
        .wrEn    (wbEn),
        .wrSel   (wbReg),
        .wrData  (wbData)
    );

    always_comb begin
        case (immSel)
            ctrlPkg::immI1Zext: immVal = {{(isaPkg::dataW-isaPkg::imm5W){1'b0}},
                                          inInstr.i1Fmt.imm};
            ctrlPkg::immI2Sext: immVal = {{(isaPkg::dataW-isaPkg::imm8W){inInstr.i2Fmt.imm[7]}},
                                          inInstr.i2Fmt.imm};
            default: immVal = {{(isaPkg::dataW-isaPkg::imm5W){inInstr.i1Fmt.imm[4]}},
                               inInstr.i1Fmt.imm};
        endcase
    end

    // JALR offset from the I2 field, JAL from the J field
    assign dispVal = jumpReg ?
        {{(isaPkg::dataW-isaPkg::imm8W){inInstr.i2Fmt.imm[7]}}, inInstr.i2Fmt.imm} :
        {{(isaPkg::dataW-isaPkg::dispW){inInstr.jFmt.disp[10]}}, inInstr.jFmt.disp};

    assign destSel = link   ? isaPkg::linkReg :
                     regDst ? inInstr.rFmt.rd :
                     i1Sel  ? inInstr.i1Fmt.rd : inInstr.i2Fmt.rs; // LBI writes Rs

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dValid   <= 1'b0;
            dOpA     <= '0;
            dOpB     <= '0;
            dImm     <= '0;
            dDisp    <= '0;
            dPc      <= '0;
            dDest    <= '0;
            dAluOp   <= '0;
            dWrite   <= 1'b0;
            dLink    <= 1'b0;
            dJump    <= 1'b0;
            dJumpReg <= 1'b0;
            dErr     <= 1'b0;
        end else begin
            if (inReady) begin
                dValid <= inValid;
            end
            if (inFire) begin
                dOpA     <= rdData1;
                dOpB     <= i1Sel ? immVal : rdData2; // I1 ops take the immediate
                dImm     <= immVal;
                dDisp    <= dispVal;
                dPc      <= inPc;
                dDest    <= destSel;
                dAluOp   <= aluOp;
                dWrite   <= writeEn;
                dLink    <= link;
                dJump    <= jump;
                dJumpReg <= jumpReg;
                dErr     <= illegal;
            end
        end
    end

endmodule

/* src/execute.sv */
// Execute stage with ALU, link and jump target logic, result register and writeback
`timescale 1ns/1ps

module execute (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        dValid,
    output logic                        dReady,
    input  logic [isaPkg::dataW-1:0]    dOpA,
    input  logic [isaPkg::dataW-1:0]    dOpB,
    input  logic [isaPkg::dataW-1:0]    dImm,
    input  logic [isaPkg::dataW-1:0]    dDisp,
    input  logic [isaPkg::dataW-1:0]    dPc,
    input  logic [isaPkg::regAddrW-1:0] dDest,
    input  logic [ctrlPkg::aluOpW-1:0]  dAluOp,
    input  logic                        dWrite,
    input  logic                        dLink,
    input  logic                        dJump,
    input  logic                        dJumpReg,
    input  logic                        dErr,
    output logic                        wbEn,
    output logic [isaPkg::regAddrW-1:0] wbReg,
    output logic [isaPkg::dataW-1:0]    wbData,
    output logic                        resValid,
    input  logic                        resReady,
    output logic [isaPkg::regAddrW-1:0] resReg,
    output logic [isaPkg::dataW-1:0]    resData,
    output logic                        resWrite,
    output logic                        resJump,
    output logic [isaPkg::dataW-1:0]    resTarget,
    output logic                        resErr
);

    logic [isaPkg::dataW-1:0] aluOut;
    logic [isaPkg::dataW-1:0] resultVal;
    logic [isaPkg::dataW-1:0] targetVal;
    logic                     dFire;

    assign dReady = !resValid || resReady;        // Result slot empty or leaving
    assign dFire  = dValid && dReady;

    always_comb begin
        case (dAluOp)
            ctrlPkg::aluAdd:     aluOut = dOpA + dOpB;
            ctrlPkg::aluSubRev:  aluOut = dOpB - dOpA; // Rt or imm minus Rs
            ctrlPkg::aluXor:     aluOut = dOpA ^ dOpB;
            ctrlPkg::aluAndn:    aluOut = dOpA & ~dOpB;
            ctrlPkg::aluPassImm: aluOut = dImm;
            default:             aluOut = '0;
        endcase
    end

    assign resultVal = dLink ? dPc : aluOut;      // Links save the return pc
    assign targetVal = dJumpReg ? (dOpA + dDisp) : (dPc + dDisp);

    // Register write happens on the same edge as the stage move
    assign wbEn   = dFire && dWrite && !dErr;
    assign wbReg  = dDest;
    assign wbData = resultVal;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resValid  <= 1'b0;
            resReg    <= '0;
            resData   <= '0;
            resWrite  <= 1'b0;
            resJump   <= 1'b0;
            resTarget <= '0;
            resErr    <= 1'b0;
        end else if (dFire) begin
            resValid  <= 1'b1;
            resReg    <= dDest;
            resData   <= resultVal;
            resWrite  <= dWrite && !dErr;
            resJump   <= dJump;
            resTarget <= dJump ? targetVal : '0; // Zero when not a jump
            resErr    <= dErr;
        end else if (resReady) begin
            resValid  <= 1'b0;                    // Slot drained
        end
    end

endmodule

/* src/coreTop.sv */
// Top level joining the control unit, decode stage and execute stage
`timescale 1ns/1ps

module coreTop (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        inValid,
    output logic                        inReady,
    input  logic [isaPkg::dataW-1:0]    inInstr,
    input  logic [isaPkg::dataW-1:0]    inPc,
    output logic                        resValid,
    input  logic                        resReady,
    output logic [isaPkg::regAddrW-1:0] resReg,
    output logic [isaPkg::dataW-1:0]    resData,
    output logic                        resWrite,
    output logic                        resJump,
    output logic [isaPkg::dataW-1:0]    resTarget,
    output logic                        resErr
);

    // Control from the word at the input
    logic [isaPkg::opW-1:0]      opcode;
    logic [isaPkg::extW-1:0]     ext;
    logic                        regDst, i1Sel, link, writeEn;
    logic                        jump, jumpReg, illegal;
    logic [ctrlPkg::aluOpW-1:0]  aluOp;
    logic [ctrlPkg::immSelW-1:0] immSel;

    // Decode to execute
    logic                        dValid, dReady;
    logic [isaPkg::dataW-1:0]    dOpA, dOpB, dImm, dDisp, dPc;
    logic [isaPkg::regAddrW-1:0] dDest;
    logic [ctrlPkg::aluOpW-1:0]  dAluOp;
    logic                        dWrite, dLink, dJump, dJumpReg, dErr;

    // Writeback into the register file
    logic                        wbEn;
    logic [isaPkg::regAddrW-1:0] wbReg;
    logic [isaPkg::dataW-1:0]    wbData;

    instrDecoder uInstrDecoder (.*);              // Names match the ports

    decode uDecode (.*);

    execute uExecute (.*);

endmodule

/* test/coreTop_sva.sv */
// Handshake stability and reset assertions bound into the core top level
`timescale 1ns/1ps

module coreTopSva (
    input logic                        clk,
    input logic                        rstN,
    input logic                        inReady,
    input logic                        dValid,
    input logic                        resValid,
    input logic                        resReady,
    input logic [isaPkg::regAddrW-1:0] resReg,
    input logic [isaPkg::dataW-1:0]    resData,
    input logic                        resWrite,
    input logic                        resJump,
    input logic [isaPkg::dataW-1:0]    resTarget,
    input logic                        resErr
);

    int failCount = 0;                            // Read by the testbench at the end

    property resHeld;                             // Stalled result must not vanish
        @(posedge clk) disable iff (!rstN)
        resValid && !resReady |=> resValid;
    endproperty

    property resStable;
        @(posedge clk) disable iff (!rstN)
        resValid && !resReady |=>
            $stable({resReg, resData, resWrite, resJump, resTarget, resErr});
    endproperty

    property resetClears;                         // Both stages empty and input open
        @(posedge clk) !rstN |=> !resValid && !dValid && inReady;
    endproperty

    assert property (resHeld) else begin
        failCount++;
        $error("resValid dropped while resReady was low");
    end

    assert property (resStable) else begin
        failCount++;
        $error("result fields changed while stalled");
    end

    assert property (resetClears) else begin
        failCount++;
        $error("valid flags not cleared by reset");
    end

endmodule

bind coreTop coreTopSva uSva (.*);

/* test/coreChecker.sv */
// Result checker with model register file, reference function and test reports
`timescale 1ns/1ps

module coreChecker (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        inValid,
    input  logic                        inReady,
    input  logic [isaPkg::dataW-1:0]    inInstr,
    input  logic [isaPkg::dataW-1:0]    inPc,
    input  logic                        resValid,
    input  logic                        resReady,
    input  logic [isaPkg::regAddrW-1:0] resReg,
    input  logic [isaPkg::dataW-1:0]    resData,
    input  logic                        resWrite,
    input  logic                        resJump,
    input  logic [isaPkg::dataW-1:0]    resTarget,
    input  logic                        resErr,
    input  logic                        testEnd,
    input  int                          testNum,
    input  logic                        allDone,
    input  int                          assertFails,
    output int                          errCount,
    output int                          pendCount
);

    logic [isaPkg::dataW-1:0] modelRegs [isaPkg::numRegs];
    logic [37:0]              expQ [$];       // {err, jump, write, dest, data, target}
    int                       checkedCnt;
    int                       testChecked;
    int                       testErrs;
    int                       testsRun;

    // Expected outcome of one word against the model registers
    function automatic logic [37:0] refResult(input isaPkg::instrWord w,
                                              input logic [15:0] pc);
        logic [15:0] rs;
        logic [15:0] rt;
        logic [15:0] sImm5;
        logic [15:0] zImm5;
        logic [15:0] sImm8;
        logic [15:0] sDisp;
        logic [15:0] data;
        logic [15:0] target;
        logic [2:0]  dest;
        logic        wr;
        logic        jmp;
        logic        err;
        rs     = modelRegs[w.rFmt.rs];
        rt     = modelRegs[w.rFmt.rt];
        sImm5  = {{11{w.i1Fmt.imm[4]}}, w.i1Fmt.imm};
        zImm5  = {11'd0, w.i1Fmt.imm};
        sImm8  = {{8{w.i2Fmt.imm[7]}}, w.i2Fmt.imm};
        sDisp  = {{5{w.jFmt.disp[10]}}, w.jFmt.disp};
        data   = '0;
        target = '0;
        dest   = '0;
        wr     = 1'b1;
        jmp    = 1'b0;
        err    = 1'b0;
        case (w.rFmt.opcode)
            isaPkg::opAlu: begin
                dest = w.rFmt.rd;                 // Rd in 4..2
                case (w.rFmt.ext)
                    isaPkg::extAdd: data = rs + rt;
                    isaPkg::extSub: data = rt - rs;
                    isaPkg::extXor: data = rs ^ rt;
                    default:        data = rs & ~rt;
                endcase
            end
            isaPkg::opAddi: begin
                dest = w.i1Fmt.rd;
                data = rs + sImm5;
            end
            isaPkg::opSubi: begin
                dest = w.i1Fmt.rd;
                data = sImm5 - rs;                // Immediate minus Rs
            end
            isaPkg::opXori: begin
                dest = w.i1Fmt.rd;
                data = rs ^ zImm5;
            end
            isaPkg::opAndni: begin
                dest = w.i1Fmt.rd;
                data = rs & ~zImm5;
            end
            isaPkg::opLbi: begin
                dest = w.i2Fmt.rs;                // LBI targets Rs
                data = sImm8;
            end
            isaPkg::opJal: begin
                dest   = isaPkg::linkReg;
                data   = pc;
                jmp    = 1'b1;
                target = pc + sDisp;
            end
            isaPkg::opJalr: begin
                dest   = isaPkg::linkReg;
                data   = pc;
                jmp    = 1'b1;
                target = modelRegs[w.i2Fmt.rs] + sImm8; // Old Rs, before the link write
            end
            default: begin
                wr  = 1'b0;
                err = 1'b1;
            end
        endcase
        return {err, jmp, wr, dest, data, target};
    endfunction

    function automatic string testName(input int n);
        case (n)
            1: return "zero reads and r-format";
            2: return "i-format immediates";
            3: return "lbi with bypass";
            4: return "jal and jalr";
            5: return "illegal opcodes";
            6: return "random with back-pressure";
            default: return "unnamed";
        endcase
    endfunction

    task automatic compareField(input string name, input logic [15:0] got,
                                input logic [15:0] want);
        if (got !== want) begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, want, $time);
            errCount++;
            testErrs++;
        end
    endtask

    task automatic checkResult(input logic [37:0] exp);
        checkedCnt++;
        testChecked++;
        compareField("resErr", 16'(resErr), 16'(exp[37]));
        compareField("resJump", 16'(resJump), 16'(exp[36]));
        compareField("resWrite", 16'(resWrite), 16'(exp[35]));
        if (!exp[37]) begin                       // Reg and data are undefined for illegal words
            compareField("resReg", 16'(resReg), 16'(exp[34:32]));
            compareField("resData", resData, exp[31:16]);
        end
        if (exp[36]) begin
            compareField("resTarget", resTarget, exp[15:0]);
        end
    endtask

    always @(posedge clk) begin
        logic [37:0] exp;
        if (!rstN) begin
            for (int i = 0; i < isaPkg::numRegs; i++) begin
                modelRegs[i] = '0;
            end
            expQ.delete();
        end else begin
            if (resValid && resReady) begin       // Output side first, it holds older items
                if (expQ.size() == 0) begin
                    $display("Result transfer at %0t with no instruction in flight", $time);
                    errCount++;
                    testErrs++;
                end else begin
                    exp = expQ.pop_front();
                    checkResult(exp);
                end
            end
            if (inValid && inReady) begin
                exp = refResult(inInstr, inPc);
                expQ.push_back(exp);
                if (exp[35]) begin
                    modelRegs[exp[34:32]] = exp[31:16]; // Program order update
                end
            end
            if (testEnd) begin
                $display("test %0d %s: %0d results checked, %0d errors",
                         testNum, testName(testNum), testChecked, testErrs);
                testChecked = 0;
                testErrs    = 0;
                testsRun++;
            end
            if (allDone) begin
                $display("%0d tests, %0d results checked, %0d errors, %0d assertion failures",
                         testsRun, checkedCnt, errCount, assertFails);
            end
        end
        pendCount = expQ.size();
    end

endmodule

/* test/tb.sv */
// Testbench top with clock, reset, random instruction stimulus and back-pressure
`timescale 1ns/1ps

module tb;

    logic                        clk = 1'b0;
    logic                        rstN;
    logic                        inValid;
    logic                        inReady;
    logic [isaPkg::dataW-1:0]    inInstr;
    logic [isaPkg::dataW-1:0]    inPc;
    logic                        resValid;
    logic                        resReady = 1'b1;
    logic [isaPkg::regAddrW-1:0] resReg;
    logic [isaPkg::dataW-1:0]    resData;
    logic                        resWrite;
    logic                        resJump;
    logic [isaPkg::dataW-1:0]    resTarget;
    logic                        resErr;
    logic                        testEnd;
    int                          testNum;
    logic                        allDone;
    int                          errCount;
    int                          pendCount;
    logic                        stallOn;         // Random resReady low periods
    logic                        gapOn;           // Random inValid gaps
    logic [31:0]                 stallRnd;        // Falling-edge draw for resReady
    int                          seed = 32'h9bfb_b146;
    int                          timeoutCycles = 500;

    always #4 clk = ~clk;                         // 8 ns period

    coreTop uut (.*);

    coreChecker chk (
        .assertFails (uut.uSva.failCount),
        .*
    );

    always @(negedge clk) begin
        stallRnd = rnd();
    end

    always @(posedge clk) begin
        if (stallOn) begin
            resReady <= (stallRnd % 4) != 0;      // Low about a quarter of the time
        end else begin
            resReady <= 1'b1;
        end
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [15:0] randPc();
        logic [31:0] r;
        r = rnd();
        return r[15:0];
    endfunction

    function automatic logic [4:0] i1Op(input logic [1:0] sel);
        case (sel)
            2'd0: return isaPkg::opAddi;
            2'd1: return isaPkg::opSubi;
            2'd2: return isaPkg::opXori;
            default: return isaPkg::opAndni;
        endcase
    endfunction

    function automatic logic [4:0] illegalOp(input logic [2:0] sel);
        case (sel)
            3'd0: return 5'b00000;
            3'd1: return 5'b00001;
            3'd2: return 5'b00010;
            3'd3: return 5'b10000;
            3'd4: return 5'b10100;
            3'd5: return 5'b11100;
            3'd6: return 5'b11111;
            default: return 5'b01100;
        endcase
    endfunction

    // Mix weighted toward ALU work with the low 11 bits always random
    function automatic logic [15:0] randInstr();
        logic [31:0] r;
        logic [4:0]  op;
        r = rnd();
        case (r[31:28] % 4'd10)
            4'd0, 4'd1, 4'd2, 4'd3: op = isaPkg::opAlu;
            4'd4, 4'd5: op = i1Op(r[12:11]);
            4'd6: op = isaPkg::opLbi;
            4'd7: op = isaPkg::opJal;
            4'd8: op = isaPkg::opJalr;
            default: op = illegalOp(r[14:12]);
        endcase
        return {op, r[10:0]};
    endfunction

    task automatic abortRun(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Test FAILED");
        $finish;
    endtask

    // Called at a rising edge and returns at the rising edge after the transfer
    task automatic sendInstr(input logic [15:0] word, input logic [15:0] pc);
        int          waitCnt;
        logic [31:0] r;
        waitCnt = 0;
        inValid <= 1'b1;
        inInstr <= word;
        inPc    <= pc;
        @(negedge clk);
        while (!inReady) begin                    // Stable between edges
            waitCnt++;
            if (waitCnt > timeoutCycles) begin
                abortRun("inReady");
            end
            @(negedge clk);
        end
        @(posedge clk);                           // Transfer edge
        r = rnd();
        if (gapOn && r[1:0] == 2'd0) begin
            inValid <= 1'b0;
            repeat (int'(r[3:2]) + 1) @(posedge clk);
        end
    endtask

    task automatic waitDrain();
        int waitCnt;
        waitCnt = 0;
        inValid <= 1'b0;
        @(negedge clk);
        while (pendCount != 0 || resValid) begin
            waitCnt++;
            if (waitCnt > timeoutCycles) begin
                abortRun("the pipeline to drain");
            end
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic finishTest(input int n);
        waitDrain();
        testNum <= n;
        testEnd <= 1'b1;
        @(posedge clk);
        testEnd <= 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        rstN    = 1'b0;
        inValid = 1'b0;
        inInstr = '0;
        inPc    = '0;
        testEnd = 1'b0;
        testNum = 0;
        allDone = 1'b0;
        stallOn = 1'b0;
        gapOn   = 1'b0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;

        // Ri = Ri + R0 reads every register straight after reset
        for (int i = 0; i < isaPkg::numRegs; i++) begin
            sendInstr({isaPkg::opAlu, 3'(i), 3'd0, 3'(i), isaPkg::extAdd}, randPc());
        end
        for (int i = 1; i < 7; i++) begin
            r = rnd();
            sendInstr({isaPkg::opLbi, 3'(i), r[7:0]}, randPc()); // Seed nonzero values
        end
        repeat (12) begin
            r = rnd();
            sendInstr({isaPkg::opAlu, r[10:0]}, randPc());
        end
        finishTest(1);

        for (int i = 0; i < 4; i++) begin
            sendInstr({i1Op(2'(i)), 3'd1, 3'd2, 5'h10}, randPc()); // Sign bit set
            sendInstr({i1Op(2'(i)), 3'd3, 3'd4, 5'h0f}, randPc());
        end
        repeat (16) begin
            r = rnd();
            sendInstr({i1Op(r[12:11]), r[10:0]}, randPc());
        end
        finishTest(2);

        // Back to back so the reader overlaps the LBI writeback
        repeat (8) begin
            r = rnd();
            sendInstr({isaPkg::opLbi, r[2:0], r[15:8]}, randPc());
            sendInstr({isaPkg::opAlu, r[2:0], r[2:0], r[5:3], isaPkg::extAdd}, randPc());
            sendInstr({isaPkg::opAddi, r[5:3], r[2:0], r[20:16]}, randPc());
        end
        finishTest(3);

        repeat (6) begin
            r = rnd();
            sendInstr({isaPkg::opJal, r[10:0]}, randPc());
            sendInstr({isaPkg::opJalr, r[13:11], r[23:16]}, randPc());
            sendInstr({isaPkg::opXori, isaPkg::linkReg, r[26:24], 5'd0}, randPc()); // Read R7
        end
        finishTest(4);

        repeat (8) begin
            r = rnd();
            sendInstr({illegalOp(r[13:11]), r[10:0]}, randPc());
        end
        for (int i = 0; i < isaPkg::numRegs; i++) begin
            sendInstr({isaPkg::opXori, 3'(i), 3'(i), 5'd0}, randPc()); // Read back unchanged
        end
        finishTest(5);

        stallOn <= 1'b1;
        gapOn   <= 1'b1;
        repeat (200) begin
            sendInstr(randInstr(), randPc());
        end
        finishTest(6);
        stallOn <= 1'b0;
        gapOn   <= 1'b0;

        allDone <= 1'b1;
        @(posedge clk);
        allDone <= 1'b0;
        @(negedge clk);                           // Closing line printed by now
        if (errCount == 0 && uut.uSva.failCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
src/isaPkg.sv
src/ctrlPkg.sv
src/instrDecoder.sv
src/regFile.sv
src/decode.sv
src/execute.sv
src/coreTop.sv
test/coreTop_sva.sv
test/coreChecker.sv
test/tb.sv

/* Makefile */
SIM       ?= verilator
TOP       ?= tb
FLIST     ?= sim.f
OBJDIR    ?= obj_dir
FLAGS     ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
RUNARGS   ?= +verilator+error+limit+1000
PASS      := Test OK

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: build
	@out="$$($(OBJDIR)/V$(TOP) $(RUNARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)
